//--- hdl/isa_pkg.sv
package isa_pkg;

    typedef logic [4:0] reg_idx_t;

    // register format
    typedef struct packed {
        logic [5:0] op;
        reg_idx_t   rs;
        reg_idx_t   rt;
        reg_idx_t   rd;
        logic [4:0] sa;
        logic [5:0] funct;
    } r_view_t;

    // immediate format, rs/rt/imm together also form the jump index
    typedef struct packed {
        logic [5:0]  op;
        reg_idx_t    rs;
        reg_idx_t    rt;
        logic [15:0] imm;
    } i_view_t;

    typedef union packed {
        r_view_t r_view;
        i_view_t i_view;
    } inst_word_t;

    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_regimm  = 6'h01;   // bltz/bgez, selected by rt
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_jal     = 6'h03;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_blez    = 6'h06;
    localparam logic [5:0] op_bgtz    = 6'h07;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_slti    = 6'h0a;
    localparam logic [5:0] op_sltiu   = 6'h0b;
    localparam logic [5:0] op_andi    = 6'h0c;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_xori    = 6'h0e;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    // special function codes
    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_srl  = 6'h02;
    localparam logic [5:0] fn_sra  = 6'h03;
    localparam logic [5:0] fn_sllv = 6'h04;
    localparam logic [5:0] fn_srlv = 6'h06;
    localparam logic [5:0] fn_srav = 6'h07;
    localparam logic [5:0] fn_jr   = 6'h08;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_nor  = 6'h27;
    localparam logic [5:0] fn_slt  = 6'h2a;
    localparam logic [5:0] fn_sltu = 6'h2b;

    localparam reg_idx_t rt_bltz = 5'h00;
    localparam reg_idx_t rt_bgez = 5'h01;

    localparam reg_idx_t reg_link = 5'd31;   // jal return address

endpackage

//--- hdl/pipe_pkg.sv
package pipe_pkg;

    localparam int word_w = 32;

    typedef logic [word_w-1:0] word_t;   // data word or pc

    // one-hot alu operation, bit positions
    localparam int alu_add_bit  = 0;
    localparam int alu_sub_bit  = 1;
    localparam int alu_slt_bit  = 2;
    localparam int alu_sltu_bit = 3;
    localparam int alu_and_bit  = 4;
    localparam int alu_nor_bit  = 5;
    localparam int alu_or_bit   = 6;
    localparam int alu_xor_bit  = 7;
    localparam int alu_sll_bit  = 8;
    localparam int alu_srl_bit  = 9;
    localparam int alu_sra_bit  = 10;

    localparam int alu_op_w = 11;

    // lui travels as add, its rs field is always zero
    typedef logic [alu_op_w-1:0] alu_op_t;

endpackage

//--- hdl/stage_latch.sv
module stage_latch (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    input  pipe_pkg::word_t     in_inst,
    input  pipe_pkg::word_t     in_pc,
    input  logic                ready_go,
    input  logic                es_allowin,
    output logic                ds_allowin,
    output logic                ds_valid,
    output logic                out_valid,
    output isa_pkg::inst_word_t ds_inst,
    output pipe_pkg::word_t     ds_pc
);

    // empty, or the held instruction leaves this cycle
    assign ds_allowin = !ds_valid || (ready_go && es_allowin);
    assign out_valid  = ds_valid && ready_go;

    // valid bit is the whole state, empty or holding
    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= in_valid;   // empties when fetch has nothing
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && ds_allowin) begin
            ds_inst <= in_inst;
            ds_pc   <= in_pc;
        end
    end

endmodule

//--- hdl/inst_decoder.sv
module inst_decoder (
    input  isa_pkg::inst_word_t ds_inst,
    output pipe_pkg::alu_op_t   alu_op,
    output logic                src1_is_sa,
    output logic                src1_is_pc,
    output logic                src2_is_imm,
    output logic                src2_is_8,
    output isa_pkg::reg_idx_t   dest,
    output logic                gpr_we,
    output logic                mem_re,
    output logic                mem_we,
    output logic                uses_rs,
    output logic                uses_rt,
    output logic                is_branch,
    output logic                is_jump_reg,
    output logic                is_jump_imm,
    output logic                inst_invalid
);

    import isa_pkg::*;
    import pipe_pkg::*;

    logic [5:0] op;
    logic [5:0] funct;
    reg_idx_t   rs;
    reg_idx_t   rt;
    reg_idx_t   rd;
    logic [4:0] sa;

    logic r_plain;   // special opcode with sa zero
    logic r_shift;   // special opcode with rs zero
    logic inst_addu, inst_subu, inst_slt, inst_sltu;
    logic inst_and, inst_or, inst_xor, inst_nor;
    logic inst_sll, inst_srl, inst_sra, inst_sllv, inst_srlv, inst_srav;
    logic inst_addiu, inst_slti, inst_sltiu, inst_andi, inst_ori, inst_xori, inst_lui;
    logic inst_lw, inst_sw;
    logic inst_beq, inst_bne, inst_blez, inst_bgtz, inst_bgez, inst_bltz;
    logic inst_j, inst_jal, inst_jr;
    logic r_two_src;
    logic i_alu;
    logic dst_is_rt;

    // same word seen through both views
    assign op    = ds_inst.i_view.op;
    assign rs    = ds_inst.i_view.rs;
    assign rt    = ds_inst.i_view.rt;
    assign rd    = ds_inst.r_view.rd;
    assign sa    = ds_inst.r_view.sa;
    assign funct = ds_inst.r_view.funct;

    assign r_plain = (op == op_special) && (sa == 5'd0);
    assign r_shift = (op == op_special) && (rs == 5'd0);

    assign inst_addu  = r_plain && (funct == fn_addu);
    assign inst_subu  = r_plain && (funct == fn_subu);
    assign inst_slt   = r_plain && (funct == fn_slt);
    assign inst_sltu  = r_plain && (funct == fn_sltu);
    assign inst_and   = r_plain && (funct == fn_and);
    assign inst_or    = r_plain && (funct == fn_or);
    assign inst_xor   = r_plain && (funct == fn_xor);
    assign inst_nor   = r_plain && (funct == fn_nor);
    assign inst_sllv  = r_plain && (funct == fn_sllv);
    assign inst_srlv  = r_plain && (funct == fn_srlv);
    assign inst_srav  = r_plain && (funct == fn_srav);
    assign inst_sll   = r_shift && (funct == fn_sll);   // also the nop
    assign inst_srl   = r_shift && (funct == fn_srl);
    assign inst_sra   = r_shift && (funct == fn_sra);
    assign inst_jr    = r_plain && (funct == fn_jr) && (rt == 5'd0) && (rd == 5'd0);
    assign inst_addiu = (op == op_addiu);
    assign inst_slti  = (op == op_slti);
    assign inst_sltiu = (op == op_sltiu);
    assign inst_andi  = (op == op_andi);   // zero-extended in execute
    assign inst_ori   = (op == op_ori);
    assign inst_xori  = (op == op_xori);
    assign inst_lui   = (op == op_lui) && (rs == 5'd0);
    assign inst_lw    = (op == op_lw);
    assign inst_sw    = (op == op_sw);
    assign inst_beq   = (op == op_beq);
    assign inst_bne   = (op == op_bne);
    assign inst_blez  = (op == op_blez) && (rt == 5'd0);
    assign inst_bgtz  = (op == op_bgtz) && (rt == 5'd0);
    assign inst_bgez  = (op == op_regimm) && (rt == rt_bgez);
    assign inst_bltz  = (op == op_regimm) && (rt == rt_bltz);
    assign inst_j     = (op == op_j);
    assign inst_jal   = (op == op_jal);

    assign r_two_src = inst_addu | inst_subu | inst_slt | inst_sltu | inst_and | inst_or
                     | inst_xor | inst_nor | inst_sllv | inst_srlv | inst_srav;
    assign i_alu     = inst_addiu | inst_slti | inst_sltiu | inst_andi | inst_ori | inst_xori;
    assign is_branch = inst_beq | inst_bne | inst_blez | inst_bgtz | inst_bgez | inst_bltz;
    assign is_jump_reg = inst_jr;
    assign is_jump_imm = inst_j | inst_jal;

    assign alu_op[alu_add_bit]  = inst_addu | inst_addiu | inst_lui | inst_lw | inst_sw
                                | inst_jal;   // jal computes pc + 8
    assign alu_op[alu_sub_bit]  = inst_subu;
    assign alu_op[alu_slt_bit]  = inst_slt | inst_slti;
    assign alu_op[alu_sltu_bit] = inst_sltu | inst_sltiu;
    assign alu_op[alu_and_bit]  = inst_and | inst_andi;
    assign alu_op[alu_nor_bit]  = inst_nor;
    assign alu_op[alu_or_bit]   = inst_or | inst_ori;
    assign alu_op[alu_xor_bit]  = inst_xor | inst_xori;
    assign alu_op[alu_sll_bit]  = inst_sll | inst_sllv;
    assign alu_op[alu_srl_bit]  = inst_srl | inst_srlv;
    assign alu_op[alu_sra_bit]  = inst_sra | inst_srav;

    assign src1_is_sa  = inst_sll | inst_srl | inst_sra;
    assign src1_is_pc  = inst_jal;
    assign src2_is_imm = i_alu | inst_lui | inst_lw | inst_sw;
    assign src2_is_8   = inst_jal;

    assign dst_is_rt = i_alu | inst_lui | inst_lw;
    assign dest      = inst_jal  ? reg_link :
                       dst_is_rt ? rt       :
                                   rd;
    assign gpr_we    = ~(inst_sw | is_branch | inst_j | inst_jr);
    assign mem_re    = inst_lw;
    assign mem_we    = inst_sw;

    // operands actually read, stalls only look at these
    assign uses_rs = r_two_src | i_alu | inst_lw | inst_sw | is_branch | inst_jr;
    assign uses_rt = r_two_src | src1_is_sa | inst_sw | inst_beq | inst_bne;

    assign inst_invalid = ~(r_two_src | src1_is_sa | i_alu | inst_lui | inst_lw | inst_sw
                          | is_branch | is_jump_imm | inst_jr);

endmodule

//--- hdl/reg_file.sv
module reg_file (
    input  logic        clk,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata
);

    logic [31:0] regs [0:31];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[waddr] <= wdata;   // r0 may be written, reads mask it
        end
    end

    // same-cycle write is not seen here, the ws bypass covers it
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : regs[raddr2];

endmodule

//--- hdl/bypass_hazard.sv
module bypass_hazard (
    input  isa_pkg::reg_idx_t rs,
    input  isa_pkg::reg_idx_t rt,
    input  logic              uses_rs,
    input  logic              uses_rt,
    input  pipe_pkg::word_t   rf_rdata1,
    input  pipe_pkg::word_t   rf_rdata2,
    input  logic              es_res_valid,
    input  isa_pkg::reg_idx_t es_dest,
    input  pipe_pkg::word_t   es_res,
    input  logic              ms_res_valid,
    input  isa_pkg::reg_idx_t ms_dest,
    input  pipe_pkg::word_t   ms_res,
    input  logic              ws_we,
    input  isa_pkg::reg_idx_t ws_dest,
    input  pipe_pkg::word_t   ws_data,
    output pipe_pkg::word_t   rs_value,
    output pipe_pkg::word_t   rt_value,
    output logic              rs_hit_es_pending,
    output logic              rt_hit_es_pending,
    output logic              ready_go
);

    logic rs_hit_es;
    logic rs_hit_ms;
    logic rs_hit_ws;
    logic rt_hit_es;
    logic rt_hit_ms;
    logic rt_hit_ws;
    logic rs_hit_ms_pending;
    logic rt_hit_ms_pending;

    // r0 never matches
    assign rs_hit_es = (rs != 5'd0) && (rs == es_dest);
    assign rs_hit_ms = (rs != 5'd0) && (rs == ms_dest);
    assign rs_hit_ws = (rs != 5'd0) && (rs == ws_dest) && ws_we;
    assign rt_hit_es = (rt != 5'd0) && (rt == es_dest);
    assign rt_hit_ms = (rt != 5'd0) && (rt == ms_dest);
    assign rt_hit_ws = (rt != 5'd0) && (rt == ws_dest) && ws_we;

    // youngest producer wins
    assign rs_value = rs_hit_es ? es_res  :
                      rs_hit_ms ? ms_res  :
                      rs_hit_ws ? ws_data :
                                  rf_rdata1;
    assign rt_value = rt_hit_es ? es_res  :
                      rt_hit_ms ? ms_res  :
                      rt_hit_ws ? ws_data :
                                  rf_rdata2;

    assign rs_hit_es_pending = rs_hit_es && !es_res_valid;   // load still in execute
    assign rt_hit_es_pending = rt_hit_es && !es_res_valid;
    assign rs_hit_ms_pending = rs_hit_ms && !ms_res_valid;
    assign rt_hit_ms_pending = rt_hit_ms && !ms_res_valid;

    assign ready_go = !(uses_rs && (rs_hit_es_pending || rs_hit_ms_pending))
                   && !(uses_rt && (rt_hit_es_pending || rt_hit_ms_pending));

endmodule

//--- hdl/branch_unit.sv
module branch_unit (
    input  isa_pkg::inst_word_t ds_inst,
    input  pipe_pkg::word_t     ds_pc,
    input  logic                ds_valid,
    input  logic                is_branch,
    input  logic                is_jump_reg,
    input  logic                is_jump_imm,
    input  pipe_pkg::word_t     rs_value,
    input  pipe_pkg::word_t     rt_value,
    input  logic                rs_hit_es_pending,
    input  logic                rt_hit_es_pending,
    output logic                br_taken,
    output logic                br_stall,
    output pipe_pkg::word_t     br_target
);

    import isa_pkg::*;
    import pipe_pkg::*;

    word_t       pc_plus4;
    word_t       br_offset;
    logic [25:0] jidx;
    logic        rs_eq_rt;
    logic        rs_is_zero;
    logic        rs_is_neg;
    logic        is_beq_bne;
    logic        cond;

    assign pc_plus4   = ds_pc + 32'd4;
    assign br_offset  = {{14{ds_inst.i_view.imm[15]}}, ds_inst.i_view.imm, 2'b00};
    assign jidx       = {ds_inst.i_view.rs, ds_inst.i_view.rt, ds_inst.i_view.imm};
    assign rs_eq_rt   = (rs_value == rt_value);
    assign rs_is_zero = (rs_value == '0);
    assign rs_is_neg  = rs_value[31];
    assign is_beq_bne = (ds_inst.i_view.op == op_beq) || (ds_inst.i_view.op == op_bne);

    // only meaningful while is_branch is high
    always_comb begin
        case (ds_inst.i_view.op)
            op_beq:    cond = rs_eq_rt;
            op_bne:    cond = !rs_eq_rt;
            op_blez:   cond = rs_is_neg || rs_is_zero;
            op_bgtz:   cond = !rs_is_neg && !rs_is_zero;
            op_regimm: cond = (ds_inst.i_view.rt == rt_bgez) ? !rs_is_neg : rs_is_neg;
            default:   cond = 1'b0;
        endcase
    end

    assign br_taken = ds_valid && ((is_branch && cond) || is_jump_reg || is_jump_imm);

    // compare operand still a load in execute
    assign br_stall = ds_valid
                   && (((is_branch || is_jump_reg) && rs_hit_es_pending)
                    || (is_branch && is_beq_bne && rt_hit_es_pending));

    assign br_target = is_jump_reg ? rs_value :
                       is_jump_imm ? {pc_plus4[31:28], jidx, 2'b00} :
                                     pc_plus4 + br_offset;

endmodule

//--- hdl/decode_stage.sv
module decode_stage (
    input  logic                clk,
    input  logic                reset,
    input  logic                in_valid,
    input  pipe_pkg::word_t     in_inst,
    input  pipe_pkg::word_t     in_pc,
    output logic                ds_allowin,
    input  logic                es_allowin,
    output logic                out_valid,
    output pipe_pkg::word_t     out_pc,
    output pipe_pkg::alu_op_t   alu_op,
    output logic                src1_is_sa,
    output logic                src1_is_pc,
    output logic                src2_is_imm,
    output logic                src2_is_8,
    output logic [15:0]         imm,
    output pipe_pkg::word_t     rs_value,
    output pipe_pkg::word_t     rt_value,
    output isa_pkg::reg_idx_t   dest,
    output logic                gpr_we,
    output logic                mem_re,
    output logic                mem_we,
    output logic                inst_invalid,
    output logic                br_taken,
    output logic                br_stall,
    output pipe_pkg::word_t     br_target,
    input  logic                es_res_valid,
    input  isa_pkg::reg_idx_t   es_dest,
    input  pipe_pkg::word_t     es_res,
    input  logic                ms_res_valid,
    input  isa_pkg::reg_idx_t   ms_dest,
    input  pipe_pkg::word_t     ms_res,
    input  logic                ws_we,
    input  isa_pkg::reg_idx_t   ws_dest,
    input  pipe_pkg::word_t     ws_data
);

    import isa_pkg::*;
    import pipe_pkg::*;

    logic       ds_valid;
    inst_word_t ds_inst;
    logic       ready_go;

    // decoder to hazard and branch logic
    logic uses_rs;
    logic uses_rt;
    logic is_branch;
    logic is_jump_reg;
    logic is_jump_imm;

    word_t rf_rdata1;
    word_t rf_rdata2;
    logic  rs_hit_es_pending;
    logic  rt_hit_es_pending;

    assign imm = ds_inst.i_view.imm;   // raw field, execute extends it

    stage_latch stage_latch_inst (
        .clk, .reset, .in_valid, .in_inst, .in_pc, .ready_go, .es_allowin,
        .ds_allowin, .ds_valid, .out_valid, .ds_inst,
        .ds_pc (out_pc)
    );

    inst_decoder inst_decoder_inst (
        .ds_inst, .alu_op, .src1_is_sa, .src1_is_pc, .src2_is_imm, .src2_is_8,
        .dest, .gpr_we, .mem_re, .mem_we, .uses_rs, .uses_rt,
        .is_branch, .is_jump_reg, .is_jump_imm, .inst_invalid
    );

    reg_file reg_file_inst (
        .clk,
        .raddr1 (ds_inst.r_view.rs),
        .raddr2 (ds_inst.r_view.rt),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .we     (ws_we),
        .waddr  (ws_dest),
        .wdata  (ws_data)
    );

    bypass_hazard bypass_hazard_inst (
        .rs (ds_inst.r_view.rs),
        .rt (ds_inst.r_view.rt),
        .uses_rs, .uses_rt, .rf_rdata1, .rf_rdata2,
        .es_res_valid, .es_dest, .es_res,
        .ms_res_valid, .ms_dest, .ms_res,
        .ws_we, .ws_dest, .ws_data,
        .rs_value, .rt_value, .rs_hit_es_pending, .rt_hit_es_pending, .ready_go
    );

    branch_unit branch_unit_inst (
        .ds_inst,
        .ds_pc (out_pc),
        .ds_valid, .is_branch, .is_jump_reg, .is_jump_imm,
        .rs_value, .rt_value, .rs_hit_es_pending, .rt_hit_es_pending,
        .br_taken, .br_stall, .br_target
    );

endmodule

//--- include/decode_tb_cases.svh
// add_case: name, inst, pc, es_allowin, stall, alu_op, flags, dest, br_taken, br_target, br_stall
// flags: src1_is_sa src1_is_pc src2_is_imm src2_is_8 gpr_we mem_re mem_we inst_invalid
// set_src: es valid/dest/res, ms valid/dest/res, ws we/dest/data, kept until the next set_src
set_src(1, 0, 0, 1, 0, 0, 0, 0, 0);
add_case("addu", r_type(1, 2, 3, 0, fn_addu), 32'h100, 1, 0, 11'h001, 8'h08, 3, 0, 0, 0);
add_case("subu", r_type(5, 6, 4, 0, fn_subu), 32'h104, 1, 0, 11'h002, 8'h08, 4, 0, 0, 0);
add_case("slt", r_type(1, 8, 7, 0, fn_slt), 32'h108, 1, 0, 11'h004, 8'h08, 7, 0, 0, 0);
add_case("sltu", r_type(2, 3, 9, 0, fn_sltu), 32'h10c, 1, 0, 11'h008, 8'h08, 9, 0, 0, 0);
add_case("nor", r_type(4, 7, 10, 0, fn_nor), 32'h110, 1, 0, 11'h020, 8'h08, 10, 0, 0, 0);
add_case("srav", r_type(7, 6, 14, 0, fn_srav), 32'h114, 1, 0, 11'h400, 8'h08, 14, 0, 0, 0);
add_case("sll", r_type(0, 5, 13, 3, fn_sll), 32'h118, 1, 0, 11'h100, 8'h88, 13, 0, 0, 0);
add_case("addiu", i_type(op_addiu, 2, 11, 16'hfff0), 32'h11c, 1, 0, 11'h001, 8'h28, 11, 0, 0, 0);
add_case("ori", i_type(op_ori, 3, 15, 16'h00ff), 32'h120, 1, 0, 11'h040, 8'h28, 15, 0, 0, 0);
add_case("lui", i_type(op_lui, 0, 12, 16'h1234), 32'h124, 1, 0, 11'h001, 8'h28, 12, 0, 0, 0);
add_case("lw", i_type(op_lw, 2, 22, 16'h0010), 32'h128, 1, 0, 11'h001, 8'h2c, 22, 0, 0, 0);
add_case("sw", i_type(op_sw, 1, 3, 16'h0004), 32'h12c, 1, 0, 11'h001, 8'h22, 0, 0, 0, 0);
add_case("invalid", i_type(6'h3f, 1, 2, 16'h0000), 32'h130, 1, 0, 11'h000, 8'h09, 0, 0, 0, 0);
// es beats ms beats ws
set_src(1, 1, 32'haaaa0001, 1, 2, 32'hbbbb0002, 1, 2, 32'hcccc0002);
add_case("fwd es/ms", r_type(1, 2, 16, 0, fn_xor), 32'h200, 1, 0, 11'h080, 8'h08, 16, 0, 0, 0);
set_src(1, 0, 0, 1, 3, 32'h12345678, 1, 4, 32'h0f0f0f0f);
add_case("fwd ms/ws", r_type(3, 4, 17, 0, fn_and), 32'h204, 1, 0, 11'h010, 8'h08, 17, 0, 0, 0);
set_src(1, 0, 32'hdeadbeef, 1, 0, 32'h11111111, 1, 0, 32'hffffffff);
add_case("r0 src", r_type(0, 5, 18, 0, fn_or), 32'h208, 1, 0, 11'h040, 8'h08, 18, 0, 0, 0);
// load still in execute or memory
set_src(0, 7, 32'h77, 1, 0, 0, 0, 0, 0);
add_case("es stall", r_type(6, 7, 19, 0, fn_addu), 32'h300, 1, 1, 11'h001, 8'h08, 19, 0, 0, 0);
add_case("no stall", i_type(op_addiu, 3, 7, 16'h0004), 32'h304, 1, 0, 11'h001, 8'h28, 7, 0, 0, 0);
set_src(1, 0, 0, 0, 8, 32'h88, 0, 0, 0);
add_case("ms stall", r_type(8, 1, 20, 0, fn_subu), 32'h308, 1, 1, 11'h002, 8'h08, 20, 0, 0, 0);
set_src(1, 1, 32'h55, 1, 2, 32'h55, 0, 0, 0);
add_case("beq t", i_type(op_beq, 1, 2, 16'h0010), 32'h1000, 1, 0, 0, 8'h00, 0, 1, 32'h1044, 0);
set_src(1, 1, 32'h55, 1, 2, 32'h56, 0, 0, 0);
add_case("bne t", i_type(op_bne, 1, 2, 16'hfffc), 32'h2000, 1, 0, 0, 8'h00, 31, 1, 32'h1ff4, 0);
add_case("beq nt", i_type(op_beq, 1, 2, 16'h0010), 32'h1000, 1, 0, 0, 8'h00, 0, 0, 0, 0);
set_src(1, 3, 32'h80000000, 1, 4, 32'h00000001, 1, 6, 32'h00000000);
add_case("bgez nt", i_type(op_regimm, 3, rt_bgez, 16'h0008), 32'h3000, 1, 0, 0, 0, 0, 0, 0, 0);
add_case("bltz t", i_type(op_regimm, 3, rt_bltz, 16'h0100), 32'h4000, 1, 0, 0, 0, 0, 1,
         32'h4404, 0);
add_case("bgtz t", i_type(op_bgtz, 4, 0, 16'h0020), 32'h3000, 1, 0, 0, 8'h00, 0, 1, 32'h3084, 0);
add_case("blez t", i_type(op_blez, 6, 0, 16'h0002), 32'h3100, 1, 0, 0, 8'h00, 0, 1, 32'h310c, 0);
set_src(1, 7, 32'h12340000, 1, 0, 0, 0, 0, 0);
add_case("jr", r_type(7, 0, 0, 0, fn_jr), 32'h5000, 1, 0, 0, 8'h00, 0, 1, 32'h12340000, 0);
add_case("j", j_type(op_j, 26'h0100040), 32'hbfc00200, 1, 0, 0, 8'h00, 0, 1, 32'hb0400100, 0);
add_case("jal", j_type(op_jal, 26'h0000100), 32'h00400000, 1, 0, 11'h001, 8'h58, 31, 1,
         32'h00000400, 0);
set_src(0, 2, 32'h0, 1, 0, 0, 0, 0, 0);
add_case("beq stall", i_type(op_beq, 0, 2, 16'h0001), 32'h5000, 1, 1, 0, 8'h00, 0, 1, 32'h5008, 1);
set_src(1, 0, 0, 1, 0, 0, 0, 0, 0);
add_case("backpress", r_type(1, 8, 21, 0, fn_addu), 32'h600, 0, 0, 11'h001, 8'h08, 21, 0, 0, 0);

//--- verification/decode_stage_tb.sv
module decode_stage_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import isa_pkg::*;
    import pipe_pkg::*;

    typedef struct {
        string      name;
        word_t      inst;
        word_t      pc;
        logic       es_v, ms_v, ws_we;
        reg_idx_t   es_d, ms_d, ws_d;
        word_t      es_r, ms_r, ws_r;
        logic       allow;      // es_allowin while held
        logic       stall;
        alu_op_t    alu;
        logic [7:0] flags;
        reg_idx_t   dest;
        logic       taken;
        word_t      target;
        logic       br_stall;
    } case_t;

    logic     clk, reset, in_valid, es_allowin, ds_allowin, out_valid;
    word_t    in_inst, in_pc, out_pc, rs_value, rt_value, br_target;
    alu_op_t  alu_op;
    logic     src1_is_sa, src1_is_pc, src2_is_imm, src2_is_8;
    logic     gpr_we, mem_re, mem_we, inst_invalid, br_taken, br_stall;
    logic [15:0] imm;
    reg_idx_t dest, es_dest, ms_dest, ws_dest;
    logic     es_res_valid, ms_res_valid, ws_we;
    word_t    es_res, ms_res, ws_data;

    case_t  cases[$];
    case_t  row_src;
    word_t  model_regs [32];
    integer seed;
    int     errors;
    int     passed;
    int     failed;
    logic   table_ready = 1'b0;

    decode_stage decode_stage_inst (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic word_t r_type(input reg_idx_t rs, input reg_idx_t rt, input reg_idx_t rd,
                                     input logic [4:0] sa, input logic [5:0] fn);
        return {op_special, rs, rt, rd, sa, fn};
    endfunction

    function automatic word_t i_type(input logic [5:0] op, input reg_idx_t rs, input reg_idx_t rt,
                                     input logic [15:0] value);
        return {op, rs, rt, value};
    endfunction

    function automatic word_t j_type(input logic [5:0] op, input logic [25:0] index);
        return {op, index};
    endfunction

    task automatic set_src(input logic es_v, input reg_idx_t es_d, input word_t es_r,
                           input logic ms_v, input reg_idx_t ms_d, input word_t ms_r,
                           input logic ws_v, input reg_idx_t ws_d, input word_t ws_r);
        row_src.es_v  = es_v;
        row_src.es_d  = es_d;
        row_src.es_r  = es_r;
        row_src.ms_v  = ms_v;
        row_src.ms_d  = ms_d;
        row_src.ms_r  = ms_r;
        row_src.ws_we = ws_v;
        row_src.ws_d  = ws_d;
        row_src.ws_r  = ws_r;
    endtask

    task automatic add_case(input string name, input word_t inst, input word_t pc,
                            input logic allow, input logic stall, input alu_op_t alu,
                            input logic [7:0] flags, input reg_idx_t dst, input logic taken,
                            input word_t target, input logic bstall);
        case_t c;
        c          = row_src;
        c.name     = name;
        c.inst     = inst;
        c.pc       = pc;
        c.allow    = allow;
        c.stall    = stall;
        c.alu      = alu;
        c.flags    = flags;
        c.dest     = dst;
        c.taken    = taken;
        c.target   = target;
        c.br_stall = bstall;
        cases.push_back(c);
    endtask

    task automatic build_table();
`include "decode_tb_cases.svh"
    endtask

    // youngest producer first, r0 is hardwired
    function automatic word_t expect_operand(input reg_idx_t r, input case_t c);
        if (r == 5'd0)
            return '0;
        if (r == c.es_d)
            return c.es_r;
        if (r == c.ms_d)
            return c.ms_r;
        if (c.ws_we && r == c.ws_d)
            return c.ws_r;
        return model_regs[r];
    endfunction

    task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_fields(input case_t c);
        word_t exp_rs;
        word_t exp_rt;
        exp_rs = expect_operand(c.inst[25:21], c);
        exp_rt = expect_operand(c.inst[20:16], c);
        check_value("out_pc", out_pc, c.pc);
        check_value("alu_op", alu_op, c.alu);
        check_value("control flags", {src1_is_sa, src1_is_pc, src2_is_imm, src2_is_8,
                                      gpr_we, mem_re, mem_we, inst_invalid}, c.flags);
        check_value("dest", dest, c.dest);
        check_value("imm", imm, c.inst[15:0]);
        if (!$isunknown(exp_rs))   // registers above 8 never loaded
            check_value("rs_value", rs_value, exp_rs);
        if (!$isunknown(exp_rt))
            check_value("rt_value", rt_value, exp_rt);
        check_value("br_taken", br_taken, c.taken);
        if (c.taken)
            check_value("br_target", br_target, c.target);
    endtask

    task automatic preload_regs();
        word_t value;
        for (int r = 1; r <= 8; r++) begin
            value = $random(seed);
            @(posedge clk);
            ws_we         <= 1'b1;
            ws_dest       <= reg_idx_t'(r);
            ws_data       <= value;
            model_regs[r]  = value;
        end
        @(posedge clk);
        ws_we <= 1'b0;
    endtask

    task automatic run_case(input int num, input case_t c);
        int      errs_before;
        int      waited;
        alu_op_t held_alu;
        word_t   held_rs;
        errs_before = errors;
        @(posedge clk);
        in_valid     <= 1'b1;
        in_inst      <= c.inst;
        in_pc        <= c.pc;
        es_allowin   <= c.allow;
        es_res_valid <= c.es_v;
        es_dest      <= c.es_d;
        es_res       <= c.es_r;
        ms_res_valid <= c.ms_v;
        ms_dest      <= c.ms_d;
        ms_res       <= c.ms_r;
        ws_we        <= c.ws_we;
        ws_dest      <= c.ws_d;
        ws_data      <= c.ws_r;
        @(posedge clk);
        in_valid <= 1'b0;   // accepted at this edge
        @(negedge clk);
        check_value("br_stall", br_stall, c.br_stall);
        if (c.stall) begin
            repeat (2) begin
                check_value("out_valid while stalled", out_valid, 1'b0);
                check_value("ds_allowin while stalled", ds_allowin, 1'b0);
                @(negedge clk);
            end
            @(posedge clk);
            es_res_valid <= 1'b1;   // load result arrives
            ms_res_valid <= 1'b1;
            @(negedge clk);
        end else begin
            check_value("out_valid one cycle after acceptance", out_valid, 1'b1);
        end
        waited = 0;
        while (!out_valid && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        assert (out_valid) else begin
            $display("test %0d (%s): out_valid never rose after the stall cleared", num, c.name);
            errors++;
        end
        if (!c.allow) begin
            held_alu = alu_op;
            held_rs  = rs_value;
            @(posedge clk);
            in_valid <= 1'b1;   // another word waits at the input
            in_inst  <= ~c.inst;
            in_pc    <= c.pc + 32'd4;
            repeat (3) begin
                @(negedge clk);
                check_value("ds_allowin under back-pressure", ds_allowin, 1'b0);
                check_value("out_valid under back-pressure", out_valid, 1'b1);
                check_value("alu_op while held", alu_op, held_alu);
                check_value("rs_value while held", rs_value, held_rs);
            end
        end
        check_fields(c);
        if (!c.allow) begin
            @(posedge clk);
            es_allowin <= 1'b1;
            in_valid   <= 1'b0;
        end
        if (c.ws_we && c.ws_d != 5'd0)
            model_regs[c.ws_d] = c.ws_r;   // writeback landed in the register file
        if (errors == errs_before) begin
            passed++;
            $display("test %0d %s pass", num, c.name);
        end else begin
            failed++;
            $display("test %0d %s fail, %0d errors", num, c.name, errors - errs_before);
        end
    endtask

    // whole table budget plus reset and preload
    initial begin
        longint limit;
        wait (table_ready);
        limit = cases.size() * 20 * 20 + 16 * 20 + 400;
        #(limit);
        $display("timeout: the run did not finish within %0d ns", limit);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        seed         = 32'ha94f;
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_inst      = '0;
        in_pc        = '0;
        es_allowin   = 1'b1;
        es_res_valid = 1'b1;
        es_dest      = '0;
        es_res       = '0;
        ms_res_valid = 1'b1;
        ms_dest      = '0;
        ms_res       = '0;
        ws_we        = 1'b0;
        ws_dest      = '0;
        ws_data      = '0;
        errors       = 0;
        passed       = 0;
        failed       = 0;
        foreach (model_regs[r])
            model_regs[r] = 'x;
        model_regs[0] = '0;
        build_table();
        table_ready = 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("out_valid after reset", out_valid, 1'b0);
        check_value("br_taken after reset", br_taken, 1'b0);
        check_value("ds_allowin after reset", ds_allowin, 1'b1);
        preload_regs();
        for (int i = 0; i < cases.size(); i++)
            run_case(i, cases[i]);
        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 cases.size(), passed, failed, errors);
        if (errors == 0 && failed == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+include
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/stage_latch.sv
hdl/inst_decoder.sv
hdl/reg_file.sv
hdl/bypass_hazard.sv
hdl/branch_unit.sv
hdl/decode_stage.sv
verification/decode_stage_tb.sv
